// ==== vlog.f ====
+incdir+.
mul_pkg.sv
mul_dispatch.sv
mul_lane.sv
mul_collect.sv
mul_farm.sv
mul_farm_chk.sv
mul_farm_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the multiply farm testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module mul_farm_tb --Mdir obj_dir -o mul_farm_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/mul_farm_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1

// ==== mul_farm_tb.sv ====
// multiply farm testbench
// table and LFSR stimulus, in-order scoreboard, latency and back-pressure checks

`timescale 1ns/1ps
`include "mul_consts.svh"

module mul_farm_tb;

  import mul_pkg::*;

  // one stimulus entry
  // operands plus the cycles resp_rdy stays low once the product shows up
  typedef struct packed {
    logic [`MUL_WIDTH-1:0] a;
    logic [`MUL_WIDTH-1:0] b;
    logic [3:0]            stall;
  } stim_t;

  localparam int TAB_N        = 12;
  localparam int RND_N        = 40;
  localparam int N_ALL        = TAB_N + RND_N;
  localparam int WATCHDOG_CYC = N_ALL * 40 + 200;

  // a, b, resp_rdy low cycles
  // entry 0 runs alone, entries 1 to 4 fill the four lanes back to back
  stim_t tab [TAB_N] = '{
    '{32'h0000_0007, 32'h0000_0009, 4'd0},
    '{32'h1234_5678, 32'h0000_1000, 4'd0},
    '{32'hFFFF_FFFB, 32'h0000_0003, 4'd0},
    '{32'hFFFF_FF9C, 32'hFFFF_FF38, 4'd0},
    '{32'h0000_0000, 32'hDEAD_BEEF, 4'd0},
    '{32'h0000_0001, 32'h8000_0001, 4'd2},
    '{32'hFFFF_FFFF, 32'h7FFF_FFFF, 4'd5},
    '{32'h8000_0000, 32'h8000_0000, 4'd0},
    '{32'h7FFF_FFFF, 32'h7FFF_FFFF, 4'd3},
    '{32'h8000_0000, 32'h7FFF_FFFF, 4'd0},
    '{32'hFFFF_FFFF, 32'hFFFF_FFFF, 4'd1},
    '{32'h0001_0000, 32'hFFFF_0000, 4'd8}
  };

  logic        clk;
  logic        reset;
  mul_req_t    req;
  logic        req_val;
  logic        req_rdy;
  mul_resp_t   resp;
  logic        resp_val;
  logic        resp_rdy;

  stim_t       ent [N_ALL];
  int          acc_cyc [N_ALL];
  logic [63:0] exp_q [$];
  logic [31:0] lfsr_state = 32'h2259;
  int          cyc = 0;
  int          errors = 0;
  int          rsp_count = 0;
  bit          started = 1'b0;

  mul_farm u_mul_farm (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // cycle count sampled only at falling edges
  always @(posedge clk) cyc <= cyc + 1;

  // ---------------------------------------------------------------------------
  // helpers
  // ---------------------------------------------------------------------------

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // exact signed product of two sign-extended operands
  function automatic logic [63:0] expected_product(input logic [31:0] a, input logic [31:0] b);
    longint sa;
    longint sb;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    return sa * sb;
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
    if (got !== exp) begin
      errors++;
      $display("mismatch %s expected %h actual %h at %0t", name, exp, got, $time);
    end
  endtask

  task automatic build_entries();
    for (int i = 0; i < TAB_N; i++) begin
      ent[i] = tab[i];
    end
    for (int i = 0; i < RND_N; i++) begin
      ent[TAB_N+i].a     = take_bits(32);
      ent[TAB_N+i].b     = take_bits(32);
      ent[TAB_N+i].stall = 4'(take_bits(3));
    end
  endtask

  // present one request and hold it until the farm takes it
  task automatic send_req(input int i);
    req.a   = ent[i].a;
    req.b   = ent[i].b;
    req_val = 1'b1;
    @(negedge clk);
    while (!req_rdy) begin
      @(negedge clk);
    end
    // the transfer is on the coming edge
    acc_cyc[i] = cyc;
    exp_q.push_back(expected_product(ent[i].a, ent[i].b));
    @(posedge clk);
    #1;
    req_val = 1'b0;
  endtask

  // four free lanes accept on consecutive edges, then intake stalls
  task automatic check_burst();
    for (int j = 2; j <= 4; j++) begin
      check_value("req accept spacing", 64'd1, 64'(acc_cyc[j] - acc_cyc[j-1]));
    end
    @(negedge clk);
    check_value("req_rdy", 64'd0, 64'(req_rdy));
    @(posedge clk);
    #1;
  endtask

  // ---------------------------------------------------------------------------
  // request side
  // ---------------------------------------------------------------------------

  initial begin : main_seq
    reset    = 1'b1;
    req      = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    build_entries();
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    check_value("req_rdy", 64'd1, 64'(req_rdy));
    check_value("resp_val", 64'd0, 64'(resp_val));
    @(posedge clk);
    #1;
    started = 1'b1;
    // lone request on an empty farm
    send_req(0);
    wait (rsp_count == 1);
    for (int i = 1; i < N_ALL; i++) begin
      send_req(i);
      if (i == 4) check_burst();
    end
    wait (rsp_count == N_ALL);
    // nothing extra may show up once the queue is drained
    repeat (10) @(posedge clk);
    @(negedge clk);
    check_value("resp_val", 64'd0, 64'(resp_val));
    if (exp_q.size() != 0) begin
      errors++;
      $display("error: %0d requests never got a response", exp_q.size());
    end
    $display("run done: %0d of %0d responses, %0d errors", rsp_count, N_ALL, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // ---------------------------------------------------------------------------
  // response side
  // ---------------------------------------------------------------------------

  initial begin : resp_side
    mul_resp_t held;
    int        stall;
    wait (started);
    @(posedge clk);
    #1;
    for (int k = 0; k < N_ALL; k++) begin
      stall    = ent[k].stall;
      resp_rdy = (stall == 0);
      @(negedge clk);
      while (!resp_val) begin
        @(negedge clk);
      end
      // latency of the first product from its accepting cycle
      if (k == 0) check_value("resp_val latency", 64'd33, 64'(cyc - acc_cyc[0]));
      held = resp;
      repeat (stall) begin
        @(negedge clk);
        check_value("resp_val", 64'd1, 64'(resp_val));
        check_value("resp.result held", held.result, resp.result);
      end
      if (stall != 0) begin
        @(posedge clk);
        #1;
        resp_rdy = 1'b1;
        @(negedge clk);
      end
      if (exp_q.size() == 0) begin
        errors++;
        $display("error: response %0d arrived with no request outstanding", k);
      end else begin
        check_value("resp.result", exp_q.pop_front(), resp.result);
      end
      @(posedge clk);
      #1;
      rsp_count++;
    end
    resp_rdy = 1'b0;
  end

  // bound on run length from the entry count
  initial begin : watchdog
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("error: run timed out after %0d cycles", WATCHDOG_CYC);
    $display("TB FAILED");
    $finish;
  end

endmodule

// ==== mul_farm_chk.sv ====
// multiply farm protocol checker
// handshake stability, single lane issue and output state after reset

`timescale 1ns/1ps
`include "mul_consts.svh"

module mul_farm_chk (
  input logic                  clk,
  input logic                  reset,
  input mul_pkg::mul_req_t     req,
  input logic                  req_val,
  input logic                  req_rdy,
  input mul_pkg::mul_resp_t    resp,
  input logic                  resp_val,
  input logic                  resp_rdy,
  input logic [`MUL_LANES-1:0] lane_req_val
);

  import mul_pkg::*;

  // a stalled request stays up with the same operands
  a_req_hold: assert property (@(posedge clk) disable iff (reset)
    req_val && !req_rdy |=> req_val && $stable(req))
    else $error("request dropped or changed while stalled");

  // a stalled product stays up with the same value
  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp))
    else $error("response dropped or changed under back-pressure");

  // dispatcher offers to one lane at most
  a_one_lane: assert property (@(posedge clk) disable iff (reset)
    $onehot0(lane_req_val))
    else $error("more than one lane offered a request");

  // farm output empty right after reset
  a_reset_idle: assert property (@(posedge clk) reset |=> !resp_val)
    else $error("resp_val high in the cycle after reset");

endmodule

bind mul_farm mul_farm_chk u_chk (
  .clk          (clk),
  .reset        (reset),
  .req          (req),
  .req_val      (req_val),
  .req_rdy      (req_rdy),
  .resp         (resp),
  .resp_val     (resp_val),
  .resp_rdy     (resp_rdy),
  .lane_req_val (lane_req_val)
);

// ==== mul_farm.sv ====
// signed multiply farm top level
// dispatcher, a row of iterative lanes and an in-order collector

`timescale 1ns/1ps
`include "mul_consts.svh"

module mul_farm (
  input  logic               clk,
  input  logic               reset,
  input  mul_pkg::mul_req_t  req,
  input  logic               req_val,
  output logic               req_rdy,
  output mul_pkg::mul_resp_t resp,
  output logic               resp_val,
  input  logic               resp_rdy
);

  import mul_pkg::*;

  // ---------------------------------------------------------------------------
  // lane links
  // ---------------------------------------------------------------------------

  mul_req_t              lane_req [`MUL_LANES];
  logic [`MUL_LANES-1:0] lane_req_val;
  logic [`MUL_LANES-1:0] lane_req_rdy;
  mul_resp_t             lane_resp [`MUL_LANES];
  logic [`MUL_LANES-1:0] lane_resp_val;
  logic [`MUL_LANES-1:0] lane_resp_rdy;

  // issue side
  mul_dispatch u_dispatch (
    .clk          (clk),
    .reset        (reset),
    .req          (req),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .lane_req     (lane_req),
    .lane_req_val (lane_req_val),
    .lane_req_rdy (lane_req_rdy)
  );

  // one multiplier per lane
  for (genvar g = 0; g < `MUL_LANES; g++) begin : g_lane
    mul_lane u_lane (
      .clk      (clk),
      .reset    (reset),
      .req      (lane_req[g]),
      .req_val  (lane_req_val[g]),
      .req_rdy  (lane_req_rdy[g]),
      .resp     (lane_resp[g]),
      .resp_val (lane_resp_val[g]),
      .resp_rdy (lane_resp_rdy[g])
    );
  end

  // drain side
  mul_collect u_collect (
    .clk           (clk),
    .reset         (reset),
    .lane_resp     (lane_resp),
    .lane_resp_val (lane_resp_val),
    .lane_resp_rdy (lane_resp_rdy),
    .resp          (resp),
    .resp_val      (resp_val),
    .resp_rdy      (resp_rdy)
  );

endmodule

// ==== mul_collect.sv ====
// round-robin response collector
// drains lane products in issue order onto the farm output

`timescale 1ns/1ps
`include "mul_consts.svh"

module mul_collect (
  input  logic                  clk,
  input  logic                  reset,
  input  mul_pkg::mul_resp_t    lane_resp [`MUL_LANES],
  input  logic [`MUL_LANES-1:0] lane_resp_val,
  output logic [`MUL_LANES-1:0] lane_resp_rdy,
  output mul_pkg::mul_resp_t    resp,
  output logic                  resp_val,
  input  logic                  resp_rdy
);

  import mul_pkg::*;

  localparam int PTR_W = $clog2(`MUL_LANES);

  logic [PTR_W-1:0] ptr_q;
  logic             ptr_wrap;
  logic             resp_xfer;

  // only the lane under the drain pointer is visible
  assign resp      = lane_resp[ptr_q];
  assign resp_val  = lane_resp_val[ptr_q];
  assign resp_xfer = resp_val && resp_rdy;
  assign ptr_wrap  = (ptr_q == PTR_W'(`MUL_LANES - 1));

  // ready goes back to the selected lane alone
  always_comb begin
    for (int i = 0; i < `MUL_LANES; i++) begin
      lane_resp_rdy[i] = resp_rdy && (ptr_q == PTR_W'(i));
    end
  end

  // drain pointer follows the issue order
  always_ff @(posedge clk) begin
    if (reset) begin
      ptr_q <= '0;
    end else if (resp_xfer) begin
      ptr_q <= ptr_wrap ? '0 : ptr_q + 1'b1;
    end
  end

endmodule

// ==== mul_lane.sv ====
// iterative signed multiplier lane
// magnitude shift-and-add over 32 steps with sign fixup at the end

`timescale 1ns/1ps
`include "mul_consts.svh"

module mul_lane (
  input  logic               clk,
  input  logic               reset,
  input  mul_pkg::mul_req_t  req,
  input  logic               req_val,
  output logic               req_rdy,
  output mul_pkg::mul_resp_t resp,
  output logic               resp_val,
  input  logic               resp_rdy
);

  import mul_pkg::*;

  localparam int W     = `MUL_WIDTH;
  localparam int PW    = 2 * `MUL_WIDTH;
  localparam int CNT_W = $clog2(`MUL_STEPS);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CALC,
    ST_DONE
  } state_t;

  state_t state_q;

  // datapath controls
  logic mcand_en;
  logic mcand_sel;
  logic mplier_en;
  logic mplier_sel;
  logic acc_en;
  logic acc_sel;
  logic add_sel;
  logic cnt_load;
  logic cnt_dec;
  logic sign_en;
  logic neg_sel;

  // datapath status
  logic cnt_zero;
  logic mplier_lsb;

  logic req_xfer;
  logic resp_xfer;

  // datapath registers
  logic [PW-1:0]    mcand_q;
  logic [W-1:0]     mplier_q;
  logic [PW-1:0]    acc_q;
  logic [CNT_W-1:0] cnt_q;
  logic             sign_q;

  logic [W-1:0]  mag_a;
  logic [W-1:0]  mag_b;
  logic [PW-1:0] mcand_next;
  logic [W-1:0]  mplier_next;
  logic [PW-1:0] acc_sum;
  logic [PW-1:0] acc_add;
  logic [PW-1:0] acc_next;
  logic [PW-1:0] acc_neg;

  assign req_xfer  = req_val && req_rdy;
  assign resp_xfer = resp_val && resp_rdy;

  // ---------------------------------------------------------------------------
  // control
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: if (req_xfer)  state_q <= ST_CALC;
        ST_CALC: if (cnt_zero)  state_q <= ST_DONE;
        ST_DONE: if (resp_xfer) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_comb begin
    req_rdy    = 1'b0;
    resp_val   = 1'b0;
    mcand_en   = 1'b0;
    mcand_sel  = 1'b0;
    mplier_en  = 1'b0;
    mplier_sel = 1'b0;
    acc_en     = 1'b0;
    acc_sel    = 1'b0;
    add_sel    = 1'b0;
    cnt_load   = 1'b0;
    cnt_dec    = 1'b0;
    sign_en    = 1'b0;
    neg_sel    = 1'b0;
    case (state_q)
      ST_IDLE: begin
        req_rdy = 1'b1;
        // load magnitudes, clear the accumulator, capture the sign
        if (req_val) begin
          mcand_en  = 1'b1;
          mplier_en = 1'b1;
          acc_en    = 1'b1;
          cnt_load  = 1'b1;
          sign_en   = 1'b1;
        end
      end
      ST_CALC: begin
        // one add/shift step per cycle
        mcand_en   = 1'b1;
        mcand_sel  = 1'b1;
        mplier_en  = 1'b1;
        mplier_sel = 1'b1;
        acc_en     = 1'b1;
        acc_sel    = 1'b1;
        add_sel    = mplier_lsb;
        cnt_dec    = ~cnt_zero;
      end
      ST_DONE: begin
        // hold here until the collector takes the product
        resp_val = 1'b1;
        neg_sel  = sign_q;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

  // ---------------------------------------------------------------------------
  // datapath
  // ---------------------------------------------------------------------------

  // magnitudes of the operands
  // most negative value maps to 2^31 as unsigned
  assign mag_a = req.a[W-1] ? (~req.a + 1'b1) : req.a;
  assign mag_b = req.b[W-1] ? (~req.b + 1'b1) : req.b;

  assign mcand_next  = mcand_sel ? (mcand_q << 1) : {{W{1'b0}}, mag_a};
  assign mplier_next = mplier_sel ? (mplier_q >> 1) : mag_b;

  // accumulate the multiplicand on a set multiplier bit
  assign acc_sum  = acc_q + mcand_q;
  assign acc_add  = add_sel ? acc_sum : acc_q;
  assign acc_next = acc_sel ? acc_add : '0;

  assign mplier_lsb = mplier_q[0];
  assign cnt_zero   = (cnt_q == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      mcand_q  <= '0;
      mplier_q <= '0;
      acc_q    <= '0;
      cnt_q    <= '0;
      sign_q   <= 1'b0;
    end else begin
      if (mcand_en) mcand_q <= mcand_next;
      if (mplier_en) mplier_q <= mplier_next;
      if (acc_en) acc_q <= acc_next;
      if (cnt_load) begin
        cnt_q <= CNT_W'(`MUL_STEPS - 1);
      end else if (cnt_dec) begin
        cnt_q <= cnt_q - 1'b1;
      end
      // product is negative when exactly one operand is
      if (sign_en) sign_q <= req.a[W-1] ^ req.b[W-1];
    end
  end

  // two's complement of the magnitude product
  assign acc_neg     = ~acc_q + 1'b1;
  assign resp.result = neg_sel ? acc_neg : acc_q;

endmodule

// ==== mul_dispatch.sv ====
// round-robin request dispatcher
// steers each farm request to the lane under the issue pointer

`timescale 1ns/1ps
`include "mul_consts.svh"

module mul_dispatch (
  input  logic                  clk,
  input  logic                  reset,
  input  mul_pkg::mul_req_t     req,
  input  logic                  req_val,
  output logic                  req_rdy,
  output mul_pkg::mul_req_t     lane_req [`MUL_LANES],
  output logic [`MUL_LANES-1:0] lane_req_val,
  input  logic [`MUL_LANES-1:0] lane_req_rdy
);

  import mul_pkg::*;

  localparam int PTR_W = $clog2(`MUL_LANES);

  logic [PTR_W-1:0] ptr_q;
  logic             ptr_wrap;
  logic             req_xfer;

  // intake waits on the pointed lane only
  // a busy lane stalls the farm so order is never broken
  assign req_rdy  = lane_req_rdy[ptr_q];
  assign req_xfer = req_val && req_rdy;
  assign ptr_wrap = (ptr_q == PTR_W'(`MUL_LANES - 1));

  // payload goes to every lane, valid only to the selected one
  always_comb begin
    for (int i = 0; i < `MUL_LANES; i++) begin
      lane_req[i]     = req;
      lane_req_val[i] = req_val && (ptr_q == PTR_W'(i));
    end
  end

  // issue pointer
  // moves to the next lane on every accepted request
  always_ff @(posedge clk) begin
    if (reset) begin
      ptr_q <= '0;
    end else if (req_xfer) begin
      ptr_q <= ptr_wrap ? '0 : ptr_q + 1'b1;
    end
  end

endmodule

// ==== mul_pkg.sv ====
// multiply farm types
// request and response payloads carried over every valid/ready link

`include "mul_consts.svh"

package mul_pkg;

  // ---------------------------------------------------------------------------
  // request payload
  // ---------------------------------------------------------------------------

  // both operands signed two's complement
  typedef struct packed {
    logic signed [`MUL_WIDTH-1:0] a;
    logic signed [`MUL_WIDTH-1:0] b;
  } mul_req_t;

  // ---------------------------------------------------------------------------
  // response payload
  // ---------------------------------------------------------------------------

  // full signed product
  typedef struct packed {
    logic signed [2*`MUL_WIDTH-1:0] result;
  } mul_resp_t;

endpackage

// ==== mul_consts.svh ====
// multiply farm constants
// lane count, operand width and iteration count shared by the farm blocks

`ifndef MUL_CONSTS_SVH
`define MUL_CONSTS_SVH

// number of parallel multiplier lanes
// issue and drain pointers are sized from this (two bits for four lanes)
`define MUL_LANES 4

// operand width in bits
// product is twice this wide
`define MUL_WIDTH 32

// add/shift iterations per product
// the lane step counter loads this minus one
`define MUL_STEPS 32

`endif
